// ==== axis2axi_rd.f ====
design/axis2axi_rd_pkg.sv
design/burst_splitter.sv
design/axi_burst_reader.sv
design/sync_fifo.sv
design/fifo_stream_out.sv
design/axis2axi_rd.sv
test/axi_mem_model.sv
test/tb_axis2axi_rd.sv

// ==== Makefile ====
# Verilator build and run for the AXI4 read master testbench

VERILATOR ?= verilator
TOP       ?= tb_axis2axi_rd
RTL_TOP   ?= axis2axi_rd
FILELIST  ?= axis2axi_rd.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= All tests passed!

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(filter design/%,$(SOURCES))
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_axis2axi_rd.sv ====
// **********************************************************
// Testbench for the AXI4 read master: clock, reset, directed
// tests, compare tasks and run timeout
// **********************************************************

`default_nettype none
`timescale 1ns/1ns

module tb_axis2axi_rd;

   localparam int MAX_BURST_W = 4;
   localparam int FIFO_ADDR_W = 5;
   localparam int FIFO_DEPTH  = 1 << FIFO_ADDR_W;
   localparam logic [31:0] DATA_KEY = 32'h5A5A_0000;
   // Beats requested over all tests
   localparam int TOTAL_BEATS    = 3 + 5 + 50 + 70 + 60 + 20;
   localparam int TIMEOUT_CYCLES = 40 * TOTAL_BEATS + 200;

   logic                           clk;
   logic                           reset;
   logic                           start;
   axis2axi_rd_pkg::addr_t         addr;
   axis2axi_rd_pkg::beat_cnt_t     length;
   logic [MAX_BURST_W:0]           max_len;
   logic                           tready = 1'b1;
   logic                           stall = 1'b0;

   wire                            busy;
   wire axis2axi_rd_pkg::beat_cnt_t remaining;
   wire axis2axi_rd_pkg::addr_t    araddr;
   wire axis2axi_rd_pkg::axi_len_t arlen;
   wire                            arvalid;
   wire                            arready;
   wire axis2axi_rd_pkg::data_t    rdata;
   wire                            rvalid;
   wire                            rlast;
   wire                            rready;
   wire                            tvalid;
   wire axis2axi_rd_pkg::data_t    tdata;

   axis2axi_rd_pkg::data_t         got_q[$];
   axis2axi_rd_pkg::addr_t         ar_addr_q[$];
   axis2axi_rd_pkg::beat_cnt_t     ar_len_q[$];
   int                             r_beats = 0;
   int                             cycle_cnt = 0;
   logic                           random_mode = 1'b0;
   logic                           tready_level = 1'b1;
   logic [31:0]                    rnd_state = 32'd68092;

   axis2axi_rd #(
      .MAX_BURST_W(MAX_BURST_W),
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) u_dut (
      .clk_i      (clk),
      .reset_i    (reset),
      .start_i    (start),
      .addr_i     (addr),
      .length_i   (length),
      .max_len_i  (max_len),
      .arready_i  (arready),
      .rdata_i    (rdata),
      .rvalid_i   (rvalid),
      .rlast_i    (rlast),
      .tready_i   (tready),
      .busy_o     (busy),
      .remaining_o(remaining),
      .araddr_o   (araddr),
      .arlen_o    (arlen),
      .arvalid_o  (arvalid),
      .rready_o   (rready),
      .tvalid_o   (tvalid),
      .tdata_o    (tdata)
   );

   axi_mem_model u_mem (
      .clk_i    (clk),
      .reset_i  (reset),
      .stall_i  (stall),
      .araddr_i (araddr),
      .arlen_i  (arlen),
      .arvalid_i(arvalid),
      .arready_o(arready),
      .rdata_o  (rdata),
      .rvalid_o (rvalid),
      .rlast_o  (rlast),
      .rready_i (rready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Stream ready and slave stalls follow xorshift values in the random test
   always @(posedge clk) begin
      rnd_state = next_random(rnd_state);
      tready <= random_mode ? rnd_state[0] : tready_level;
      stall  <= random_mode && (rnd_state[9:8] == 2'b00);
   end

   // Log of stream words, AR requests and accepted R beats
   always @(posedge clk) begin
      if (!reset) begin
         if (tvalid && tready) begin
            got_q.push_back(tdata);
         end
         if (arvalid && arready) begin
            ar_addr_q.push_back(araddr);
            ar_len_q.push_back(axis2axi_rd_pkg::beat_cnt_t'(arlen));
         end
         if (rvalid && rready) begin
            r_beats = r_beats + 1;
         end
      end
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1, "stopped at the first error");
   endtask

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > TIMEOUT_CYCLES) begin
         stop_on_error($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
      end
   end

   task automatic check_data(input string name, input axis2axi_rd_pkg::data_t got,
                             input axis2axi_rd_pkg::data_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_addr(input string name, input axis2axi_rd_pkg::addr_t got,
                             input axis2axi_rd_pkg::addr_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input axis2axi_rd_pkg::beat_cnt_t got,
                              input axis2axi_rd_pkg::beat_cnt_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic clear_logs();
      got_q.delete();
      ar_addr_q.delete();
      ar_len_q.delete();
      r_beats = 0;
   endtask

   task automatic send_start(input axis2axi_rd_pkg::addr_t base, input int n, input int mx);
      @(posedge clk);
      start   <= 1'b1;
      addr    <= base;
      length  <= axis2axi_rd_pkg::beat_cnt_t'(n);
      max_len <= (MAX_BURST_W+1)'(mx);
      @(posedge clk);
      start <= 1'b0;
   endtask

   // AXI side finished and every word taken from the stream
   task automatic wait_done(input int n);
      @(negedge clk);
      while (busy || got_q.size() < n) begin
         @(negedge clk);
      end
   endtask

   task automatic check_stream(input axis2axi_rd_pkg::addr_t base, input int n);
      axis2axi_rd_pkg::addr_t a;
      int i;
      check_count("stream word count", axis2axi_rd_pkg::beat_cnt_t'(got_q.size()),
                  axis2axi_rd_pkg::beat_cnt_t'(n));
      for (i = 0; i < n; i++) begin
         a = base + axis2axi_rd_pkg::addr_t'(4 * i);
         check_data($sformatf("tdata_o word %0d", i), got_q[i], a ^ DATA_KEY);
      end
      check_count("R beats accepted", axis2axi_rd_pkg::beat_cnt_t'(r_beats),
                  axis2axi_rd_pkg::beat_cnt_t'(n));
      check_bit("tvalid_o after drain", tvalid, 1'b0);
   endtask

   // Each burst is the smaller of the remaining count and max_len
   task automatic check_bursts(input axis2axi_rd_pkg::addr_t base, input int n, input int mx);
      axis2axi_rd_pkg::addr_t a;
      int rem;
      int len;
      int idx;
      a = base;
      rem = n;
      idx = 0;
      while (rem > 0) begin
         len = (rem < mx) ? rem : mx;
         if (idx >= ar_addr_q.size()) begin
            stop_on_error("Fewer AR requests were issued than the transfer needs");
         end
         check_addr($sformatf("araddr of burst %0d", idx), ar_addr_q[idx], a);
         check_count($sformatf("arlen of burst %0d", idx), ar_len_q[idx],
                     axis2axi_rd_pkg::beat_cnt_t'(len - 1));
         a = a + axis2axi_rd_pkg::addr_t'(4 * len);
         rem = rem - len;
         idx = idx + 1;
      end
      check_count("AR request count", axis2axi_rd_pkg::beat_cnt_t'(ar_addr_q.size()),
                  axis2axi_rd_pkg::beat_cnt_t'(idx));
   endtask

   task automatic run_transfer(input axis2axi_rd_pkg::addr_t base, input int n, input int mx);
      clear_logs();
      send_start(base, n, mx);
      wait_done(n);
      check_stream(base, n);
      check_bursts(base, n, mx);
   endtask

   task automatic test_reset_and_start();
      clear_logs();
      check_bit("busy_o", busy, 1'b0);
      check_bit("arvalid_o", arvalid, 1'b0);
      check_bit("rready_o", rready, 1'b0);
      check_bit("tvalid_o", tvalid, 1'b0);
      check_count("remaining_o", remaining, '0);
      @(posedge clk);
      start   <= 1'b1;
      addr    <= 32'h40;
      length  <= 16'd3;
      max_len <= 5'd16;
      @(negedge clk);
      check_bit("busy_o before start is taken", busy, 1'b0);
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      check_bit("busy_o one cycle after start", busy, 1'b1);
      wait_done(3);
      check_stream(32'h40, 3);
      check_bursts(32'h40, 3, 16);
   endtask

   task automatic test_short_transfer();
      run_transfer(32'h100, 5, 16);
   endtask

   task automatic test_long_transfer();
      run_transfer(32'h200, 50, 16);
   endtask

   task automatic test_random_flow();
      random_mode = 1'b1;
      run_transfer(32'h400, 70, 7);
      random_mode = 1'b0;
   endtask

   task automatic test_backpressure();
      logic seen_valid;
      int i;
      clear_logs();
      seen_valid = 1'b0;
      tready_level = 1'b0;
      send_start(32'h800, 60, 16);
      for (i = 0; i < 150; i++) begin
         @(negedge clk);
         check_bit("R beats within FIFO depth plus one", r_beats <= FIFO_DEPTH + 1, 1'b1);
         if (seen_valid) begin
            check_bit("tvalid_o under back-pressure", tvalid, 1'b1);
            check_data("tdata_o under back-pressure", tdata, 32'h800 ^ DATA_KEY);
         end
         seen_valid = seen_valid || tvalid;
      end
      check_bit("busy_o while stalled", busy, 1'b1);
      // Two full bursts fill the FIFO and the third waits for room
      check_count("remaining_o while stalled", remaining,
                  axis2axi_rd_pkg::beat_cnt_t'(60 - 2 * 16));
      tready_level = 1'b1;
      wait_done(60);
      check_stream(32'h800, 60);
      check_bursts(32'h800, 60, 16);
   endtask

   task automatic test_start_while_busy();
      clear_logs();
      send_start(32'hA00, 20, 16);
      @(negedge clk);
      while (ar_addr_q.size() == 0) begin
         @(negedge clk);
      end
      check_bit("busy_o before second start", busy, 1'b1);
      @(posedge clk);
      start  <= 1'b1;
      addr   <= 32'hC00;
      length <= 16'd40;
      @(posedge clk);
      start <= 1'b0;
      wait_done(20);
      check_stream(32'hA00, 20);
      check_bursts(32'hA00, 20, 16);
   endtask

   initial begin
      reset   = 1'b1;
      start   = 1'b0;
      addr    = '0;
      length  = '0;
      max_len = '0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      test_reset_and_start();
      test_short_transfer();
      test_long_transfer();
      test_random_flow();
      test_backpressure();
      test_start_while_busy();
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/axi_mem_model.sv ====
// **********************************************************
// AXI4 read slave model over a word array, one burst at a
// time, with a stall input that throttles rvalid
// **********************************************************

`default_nettype none
`timescale 1ns/1ns

module axi_mem_model #(
   parameter int MEM_ADDR_W = 11
) (
   input  wire                             clk_i,
   input  wire                             reset_i,
   input  wire                             stall_i,
   input  wire axis2axi_rd_pkg::addr_t     araddr_i,
   input  wire axis2axi_rd_pkg::axi_len_t  arlen_i,
   input  wire                             arvalid_i,
   output logic                            arready_o,
   output axis2axi_rd_pkg::data_t          rdata_o,
   output logic                            rvalid_o,
   output logic                            rlast_o,
   input  wire                             rready_i
);

   typedef enum logic [1:0] {
      IDLE,
      WAIT,
      DATA
   } state_t;

   localparam int AR_DELAY = 2;

   axis2axi_rd_pkg::data_t    mem [1 << MEM_ADDR_W];
   state_t                    state_q;
   axis2axi_rd_pkg::addr_t    addr_q;
   axis2axi_rd_pkg::axi_len_t beats_left_q;
   logic [1:0]                delay_q;
   logic                      rvalid_q;

   // Word at byte address A holds A xor 5A5A0000
   initial begin
      int i;
      for (i = 0; i < (1 << MEM_ADDR_W); i++) begin
         mem[i] = axis2axi_rd_pkg::addr_t'(i * 4) ^ 32'h5A5A_0000;
      end
   end

   assign arready_o = (state_q == IDLE);
   assign rvalid_o  = rvalid_q;
   assign rlast_o   = (beats_left_q == '0);
   assign rdata_o   = mem[addr_q[MEM_ADDR_W+1:2]];

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q  <= IDLE;
         rvalid_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (arvalid_i) begin
                  addr_q       <= araddr_i;
                  beats_left_q <= arlen_i;
                  delay_q      <= 2'(AR_DELAY);
                  state_q      <= WAIT;
               end
            end
            WAIT: begin
               if (delay_q == '0) begin
                  state_q <= DATA;
               end else begin
                  delay_q <= delay_q - 2'd1;
               end
            end
            DATA: begin
               if (rvalid_q && rready_i) begin
                  if (rlast_o) begin
                     rvalid_q <= 1'b0;
                     state_q  <= IDLE;
                  end else begin
                     addr_q       <= addr_q + 32'd4;
                     beats_left_q <= beats_left_q - 8'd1;
                     rvalid_q     <= !stall_i;
                  end
               end else if (!rvalid_q) begin
                  rvalid_q <= !stall_i;
               end
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/axis2axi_rd.sv ====
// **********************************************************
// AXI4 read master top: splitter, burst reader, buffer FIFO
// and stream output stage
// **********************************************************

`default_nettype none
`timescale 1ns/1ns

module axis2axi_rd #(
   parameter int MAX_BURST_W = 4,
   parameter int FIFO_ADDR_W = 5
) (
   input  wire                                clk_i,
   input  wire                                reset_i,
   input  wire                                start_i,
   input  wire axis2axi_rd_pkg::addr_t        addr_i,
   input  wire axis2axi_rd_pkg::beat_cnt_t    length_i,
   input  wire [MAX_BURST_W:0]                max_len_i,
   input  wire                                arready_i,
   input  wire axis2axi_rd_pkg::data_t        rdata_i,
   input  wire                                rvalid_i,
   input  wire                                rlast_i,
   input  wire                                tready_i,
   output wire                                busy_o,
   output wire axis2axi_rd_pkg::beat_cnt_t    remaining_o,
   output wire axis2axi_rd_pkg::addr_t        araddr_o,
   output wire axis2axi_rd_pkg::axi_len_t     arlen_o,
   output wire                                arvalid_o,
   output wire                                rready_o,
   output wire                                tvalid_o,
   output wire axis2axi_rd_pkg::data_t        tdata_o
);

   wire                         burst_start;
   axis2axi_rd_pkg::addr_t      burst_addr;
   wire [MAX_BURST_W:0]         burst_len;
   wire                         burst_busy;

   axis2axi_rd_pkg::data_t      fifo_wdata;
   wire                         fifo_wen;
   wire                         fifo_full;
   wire                         fifo_ren;
   axis2axi_rd_pkg::data_t      fifo_rdata;
   wire                         fifo_empty;
   wire [FIFO_ADDR_W:0]         fifo_level;

   burst_splitter #(
      .MAX_BURST_W(MAX_BURST_W),
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) u_splitter (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .start_i      (start_i),
      .addr_i       (addr_i),
      .length_i     (length_i),
      .max_len_i    (max_len_i),
      .fifo_level_i (fifo_level),
      .reader_busy_i(burst_busy),
      .busy_o       (busy_o),
      .remaining_o  (remaining_o),
      .burst_start_o(burst_start),
      .burst_addr_o (burst_addr),
      .burst_len_o  (burst_len)
   );

   axi_burst_reader #(
      .MAX_BURST_W(MAX_BURST_W)
   ) u_reader (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .burst_start_i(burst_start),
      .burst_addr_i (burst_addr),
      .burst_len_i  (burst_len),
      .arready_i    (arready_i),
      .rdata_i      (rdata_i),
      .rvalid_i     (rvalid_i),
      .rlast_i      (rlast_i),
      .fifo_full_i  (fifo_full),
      .busy_o       (burst_busy),
      .araddr_o     (araddr_o),
      .arlen_o      (arlen_o),
      .arvalid_o    (arvalid_o),
      .rready_o     (rready_o),
      .fifo_wdata_o (fifo_wdata),
      .fifo_wen_o   (fifo_wen)
   );

   // Buffer between the R channel and the output stream
   sync_fifo #(
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) u_fifo (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .w_en_i   (fifo_wen),
      .w_data_i (fifo_wdata),
      .r_en_i   (fifo_ren),
      .w_full_o (fifo_full),
      .r_data_o (fifo_rdata),
      .r_empty_o(fifo_empty),
      .level_o  (fifo_level)
   );

   fifo_stream_out u_stream_out (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .fifo_empty_i(fifo_empty),
      .fifo_rdata_i(fifo_rdata),
      .tready_i    (tready_i),
      .fifo_read_o (fifo_ren),
      .tvalid_o    (tvalid_o),
      .tdata_o     (tdata_o)
   );

endmodule

`default_nettype wire

// ==== design/fifo_stream_out.sv ====
// **********************************************************
// Read-ahead stage from FIFO to a valid/ready stream
// **********************************************************

`default_nettype none
`timescale 1ns/1ns

module fifo_stream_out (
   input  wire                          clk_i,
   input  wire                          reset_i,
   input  wire                          fifo_empty_i,
   input  wire axis2axi_rd_pkg::data_t  fifo_rdata_i,
   input  wire                          tready_i,
   output logic                         fifo_read_o,
   output logic                         tvalid_o,
   output axis2axi_rd_pkg::data_t       tdata_o
);

   // Read issued last cycle, word now on the FIFO read port
   logic pending_q;
   // Word shown earlier and not yet taken
   logic held_q;

   // The FIFO read register is the output register, and it
   // keeps its word while no new read is issued
   assign tvalid_o = pending_q || held_q;
   assign tdata_o  = fifo_rdata_i;

   // Refill when the output slot is empty or drains this cycle
   assign fifo_read_o = !fifo_empty_i && (!tvalid_o || tready_i);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pending_q <= 1'b0;
         held_q    <= 1'b0;
      end else begin
         pending_q <= fifo_read_o;
         held_q    <= tvalid_o && !tready_i;
      end
   end

endmodule

`default_nettype wire

// ==== design/sync_fifo.sv ====
// **********************************************************
// Single-clock FIFO with registered read data and level
// **********************************************************

`default_nettype none
`timescale 1ns/1ns

module sync_fifo #(
   parameter int FIFO_ADDR_W = 5
) (
   input  wire                          clk_i,
   input  wire                          reset_i,
   input  wire                          w_en_i,
   input  wire axis2axi_rd_pkg::data_t  w_data_i,
   input  wire                          r_en_i,
   output logic                         w_full_o,
   output axis2axi_rd_pkg::data_t       r_data_o,
   output logic                         r_empty_o,
   output logic [FIFO_ADDR_W:0]         level_o
);

   localparam int DEPTH = 1 << FIFO_ADDR_W;
   localparam logic [FIFO_ADDR_W:0] FULL_LEVEL = (FIFO_ADDR_W+1)'(DEPTH);

   axis2axi_rd_pkg::data_t  mem [DEPTH];
   logic [FIFO_ADDR_W-1:0]  wptr_q;
   logic [FIFO_ADDR_W-1:0]  rptr_q;
   logic [FIFO_ADDR_W:0]    level_q;
   axis2axi_rd_pkg::data_t  rdata_q;
   logic                    do_write;
   logic                    do_read;

   assign w_full_o  = (level_q == FULL_LEVEL);
   assign r_empty_o = (level_q == '0);

   // Requests past full or empty are dropped here
   assign do_write = w_en_i && !w_full_o;
   assign do_read  = r_en_i && !r_empty_o;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         level_q <= '0;
      end else begin
         if (do_write) begin
            wptr_q <= wptr_q + 1'b1;
         end
         if (do_read) begin
            rptr_q <= rptr_q + 1'b1;
         end
         if (do_write && !do_read) begin
            level_q <= level_q + 1'b1;
         end else if (do_read && !do_write) begin
            level_q <= level_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_write) begin
         mem[wptr_q] <= w_data_i;
      end
   end

   // Read word holds until the next read
   always_ff @(posedge clk_i) begin
      if (do_read) begin
         rdata_q <= mem[rptr_q];
      end
   end

   assign r_data_o = rdata_q;
   assign level_o  = level_q;

endmodule

`default_nettype wire

// ==== design/axi_burst_reader.sv ====
// **********************************************************
// AXI4 burst reader: one AR request per burst, R beats
// written straight into the buffer FIFO
// **********************************************************

`default_nettype none
`timescale 1ns/1ns

module axi_burst_reader #(
   parameter int MAX_BURST_W = 4
) (
   input  wire                             clk_i,
   input  wire                             reset_i,
   input  wire                             burst_start_i,
   input  wire axis2axi_rd_pkg::addr_t     burst_addr_i,
   input  wire [MAX_BURST_W:0]             burst_len_i,
   input  wire                             arready_i,
   input  wire axis2axi_rd_pkg::data_t     rdata_i,
   input  wire                             rvalid_i,
   input  wire                             rlast_i,
   input  wire                             fifo_full_i,
   output logic                            busy_o,
   output axis2axi_rd_pkg::addr_t          araddr_o,
   output axis2axi_rd_pkg::axi_len_t       arlen_o,
   output logic                            arvalid_o,
   output logic                            rready_o,
   output axis2axi_rd_pkg::data_t          fifo_wdata_o,
   output logic                            fifo_wen_o
);

   typedef enum logic [1:0] {
      IDLE,
      ADDR,
      DATA
   } state_t;

   state_t                    state_q;
   axis2axi_rd_pkg::addr_t    araddr_q;
   axis2axi_rd_pkg::axi_len_t arlen_q;
   logic                      r_accept;

   // R beats only taken while the FIFO can store them
   assign rready_o = (state_q == DATA) && !fifo_full_i;
   assign r_accept = rvalid_i && rready_o;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE: begin
               if (burst_start_i) begin
                  state_q <= ADDR;
               end
            end
            ADDR: begin
               if (arready_i) begin
                  state_q <= DATA;
               end
            end
            DATA: begin
               if (r_accept && rlast_i) begin
                  state_q <= IDLE;
               end
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   // Request held stable while arvalid is up
   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && burst_start_i) begin
         araddr_q <= burst_addr_i;
         arlen_q  <= axis2axi_rd_pkg::axi_len_t'(burst_len_i - 1'b1);
      end
   end

   assign busy_o       = (state_q != IDLE);
   assign arvalid_o    = (state_q == ADDR);
   assign araddr_o     = araddr_q;
   assign arlen_o      = arlen_q;
   assign fifo_wen_o   = r_accept;
   assign fifo_wdata_o = rdata_i;

endmodule

`default_nettype wire

// ==== design/burst_splitter.sv ====
// **********************************************************
// Burst splitter: cuts a transfer into AXI bursts that fit
// both the maximum burst length and the free FIFO space
// **********************************************************

`default_nettype none
`timescale 1ns/1ns

module burst_splitter #(
   parameter int MAX_BURST_W = 4,
   parameter int FIFO_ADDR_W = 5
) (
   input  wire                                clk_i,
   input  wire                                reset_i,
   input  wire                                start_i,
   input  wire axis2axi_rd_pkg::addr_t        addr_i,
   input  wire axis2axi_rd_pkg::beat_cnt_t    length_i,
   input  wire [MAX_BURST_W:0]                max_len_i,
   input  wire [FIFO_ADDR_W:0]                fifo_level_i,
   input  wire                                reader_busy_i,
   output logic                               busy_o,
   output axis2axi_rd_pkg::beat_cnt_t         remaining_o,
   output logic                               burst_start_o,
   output axis2axi_rd_pkg::addr_t             burst_addr_o,
   output logic [MAX_BURST_W:0]               burst_len_o
);

   typedef enum logic {
      IDLE,
      ISSUE
   } state_t;

   localparam logic [FIFO_ADDR_W:0] FIFO_DEPTH = (FIFO_ADDR_W+1)'(1 << FIFO_ADDR_W);

   state_t                     state_q;
   axis2axi_rd_pkg::beat_cnt_t remaining_q;
   axis2axi_rd_pkg::addr_t     next_addr_q;

   logic [FIFO_ADDR_W:0]       free_space;
   axis2axi_rd_pkg::beat_cnt_t free_beats;
   axis2axi_rd_pkg::beat_cnt_t max_beats;
   axis2axi_rd_pkg::beat_cnt_t burst_beats;
   axis2axi_rd_pkg::addr_t     burst_bytes;
   logic [MAX_BURST_W:0]       burst_len;
   logic                       burst_go;

   // Everything compared in beat-count width
   assign free_space  = FIFO_DEPTH - fifo_level_i;
   assign free_beats  = axis2axi_rd_pkg::beat_cnt_t'(free_space);
   assign max_beats   = axis2axi_rd_pkg::beat_cnt_t'(max_len_i);
   assign burst_beats = axis2axi_rd_pkg::beat_cnt_t'(burst_len);
   assign burst_bytes = axis2axi_rd_pkg::addr_t'(burst_beats)
                        * axis2axi_rd_pkg::addr_t'(axis2axi_rd_pkg::BYTES_PER_BEAT);

   // Length of the next burst, zero when none can go out
   always_comb begin
      burst_len = '0;
      if (state_q == ISSUE && !reader_busy_i && remaining_q != '0) begin
         if (remaining_q <= max_beats && remaining_q <= free_beats) begin
            // Tail of the transfer fits in one burst
            burst_len = remaining_q[MAX_BURST_W:0];
         end else if (free_beats >= max_beats) begin
            burst_len = max_len_i;
         end
      end
   end

   assign burst_go = (burst_len != '0);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q     <= IDLE;
         remaining_q <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (start_i) begin
                  remaining_q <= length_i;
                  state_q     <= ISSUE;
               end
            end
            ISSUE: begin
               if (burst_go) begin
                  remaining_q <= remaining_q - burst_beats;
               end else if (remaining_q == '0 && !reader_busy_i) begin
                  // Last burst has fully landed in the FIFO
                  state_q <= IDLE;
               end
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && start_i) begin
         next_addr_q <= addr_i;
      end else if (burst_go) begin
         next_addr_q <= next_addr_q + burst_bytes;
      end
   end

   assign busy_o        = (state_q != IDLE);
   assign remaining_o   = remaining_q;
   assign burst_start_o = burst_go;
   assign burst_addr_o  = next_addr_q;
   assign burst_len_o   = burst_len;

endmodule

`default_nettype wire

// ==== design/axis2axi_rd_pkg.sv ====
// **********************************************************
// Shared types and bus constants for the AXI read master
// **********************************************************

`default_nettype none

package axis2axi_rd_pkg;

   // Byte address on the AXI bus
   typedef logic [31:0] addr_t;

   // One 32-bit data beat
   typedef logic [31:0] data_t;

   // Transfer length or remaining count, in beats
   typedef logic [15:0] beat_cnt_t;

   // Width of arlen, fixed by AXI4
   localparam int AXI_LEN_W = 8;

   typedef logic [AXI_LEN_W-1:0] axi_len_t;

   // Address step of one 32-bit beat
   localparam int BYTES_PER_BEAT = 4;

endpackage

`default_nettype wire
